//--- list.f
design/decodePkg.sv
design/immGen.sv
design/regTargetSel.sv
design/instrDecoder.sv
design/decodeQueue.sv
design/decodeUnit.sv
verification/clkGen.sv
verification/decodeUnitTb.sv

//--- run.sh
#!/bin/sh
# Build the decode stage testbench with Verilator, run it and check the log

verilator --binary --timing -Wno-fatal --top-module decodeUnitTb -f list.f -o decodeSim \
	&& ./obj_dir/decodeSim > sim.log 2>&1 \
	|| { echo "Build or simulation run failed"; exit 1; }

grep -q "TEST RESULT: PASS" sim.log \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed, see sim.log"; exit 1; }

//--- verification/decodeUnitTb.sv
// Decode stage testbench
// Drives fetch words through the valid/ready handshake, predicts every
// bundle with a reference decoder and checks order, handshake and fields

`timescale 1ns/10ps

module decodeUnitTb;

	typedef struct packed {
		logic [39:0]        word;
		decodePkg::unitE    unitClass;
		decodePkg::memSizeE memSize;
		logic               isLoad, isStore, isPush, isPop, isBranch, isJmp;
		logic               canExcept, hasConst;
		logic [63:0]        constVal;
		decodePkg::regTagT  rdTag, rd2Tag;
		logic               regWrite, btUpdate, serialize;
	} bundleT;

	// About 950 words at up to two cycles each, then doubled
	localparam int cycleLimit = 4000;

	localparam logic [7:0] opList [26] = '{decodePkg::LDB, decodePkg::LDW, decodePkg::LDT,
		decodePkg::LDO, decodePkg::POP, decodePkg::LEA, decodePkg::STB, decodePkg::STW,
		decodePkg::STT, decodePkg::STO, decodePkg::PUSH, decodePkg::ADDI, decodePkg::ANDI,
		decodePkg::ORI, decodePkg::CMPI, decodePkg::MULI, decodePkg::DIVI, decodePkg::R2,
		decodePkg::JSR, decodePkg::RTS, decodePkg::JRL, decodePkg::BEQ, decodePkg::BNE,
		decodePkg::BLT, decodePkg::MISC, decodePkg::FLT2};
	localparam logic [5:0] funcList [10] = '{decodePkg::ADD, decodePkg::RTI, decodePkg::SYNC,
		decodePkg::WAIT, decodePkg::FADD, decodePkg::CMP, decodePkg::FMUL, decodePkg::FDIV,
		decodePkg::MUL, decodePkg::DIV};

	logic clk, rst, inValid, debugOn, outReady, inReady, outValid;
	logic [39:0] instr;
	decodePkg::unitE unitClass;
	decodePkg::memSizeE memSize;
	logic isLoad, isStore, isPush, isPop, isBranch, isJmp, canExcept, hasConst;
	logic [63:0] constVal;
	decodePkg::regTagT rdTag, rd2Tag;
	logic regWrite, btUpdate, serialize;

	logic [31:0] seed;
	logic stallOn;
	logic [39:0] curWord;
	bundleT expQ[$];
	int errCount = 0, passCount = 0, sentCount = 0, recvCount = 0, modelCount = 0;
	int cycleCount = 0;

	clkGen clocks (.clk(clk), .rst(rst));

	decodeUnit dut (.clk(clk), .rst(rst), .inValid(inValid), .instr(instr),
		.debugOn(debugOn), .outReady(outReady), .inReady(inReady), .outValid(outValid),
		.unitClass(unitClass), .memSize(memSize), .isLoad(isLoad), .isStore(isStore),
		.isPush(isPush), .isPop(isPop), .isBranch(isBranch), .isJmp(isJmp),
		.canExcept(canExcept), .hasConst(hasConst), .constVal(constVal),
		.rdTag(rdTag), .rd2Tag(rd2Tag), .regWrite(regWrite),
		.btUpdate(btUpdate), .serialize(serialize));

	// ======================================================================
	// Reference decoder
	// ======================================================================
	function automatic bundleT decodeRef(input logic [39:0] w, input logic dbg);
		bundleT b;
		logic [7:0] op;
		logic [5:0] fn;
		logic [4:0] rd;
		logic mem;
		begin
			b = '0;
			op = w[7:0];
			fn = w[35:30];
			rd = w[12:8];
			mem = !op[7];
			b.word = w;
			if (mem)
				b.unitClass = decodePkg::unitMem;
			else if (!op[6])
				b.unitClass = decodePkg::unitAlu;
			else if (op[7:4] == 4'hE)
				b.unitClass = decodePkg::unitFpu;
			else if (!op[5])
				b.unitClass = decodePkg::unitFlow;
			else
				b.unitClass = decodePkg::unitNone;
			// Sized accesses carry the size in the low two opcode bits
			if (mem && op[3:2] == 2'b00)
				b.memSize = decodePkg::memSizeE'({1'b0, op[1:0]});
			else
				b.memSize = decodePkg::hexi;
			b.isLoad = mem && !op[5] && op != decodePkg::LEA;
			b.isStore = mem && op[5];
			b.isPush = (op == decodePkg::PUSH);
			b.isPop = (op == decodePkg::POP);
			b.isBranch = (op >= decodePkg::BEQ) && (op <= decodePkg::BLT);
			b.isJmp = (op == decodePkg::JSR) && (rd == 5'd0);
			b.canExcept = dbg || mem || op == decodePkg::MULI || op == decodePkg::DIVI ||
				(op == decodePkg::R2 && (fn == decodePkg::MUL || fn == decodePkg::DIV)) ||
				(op == decodePkg::FLT2 && (fn == decodePkg::FADD || fn == decodePkg::FMUL ||
				fn == decodePkg::FDIV)) || (op == decodePkg::MISC && fn == decodePkg::BRK);
			if (op >= decodePkg::ADDI && op <= decodePkg::DIVI)
				b.constVal = {{42{w[39]}}, w[39:18]};
			else if (op == decodePkg::JRL)
				b.constVal = {{37{w[39]}}, w[39:13]};
			else if (mem && !b.isPush && !b.isPop && w[29:28] == 2'd0)
				b.constVal = {{49{w[39]}}, w[39:30], w[27:23]};
			b.hasConst = (op >= decodePkg::ADDI && op <= decodePkg::DIVI) ||
				op == decodePkg::JRL || (mem && !b.isPush && !b.isPop && w[29:28] == 2'd0);
			// Destination tags
			if (op == decodePkg::CMPI || ((op == decodePkg::R2 || op == decodePkg::FLT2) &&
				fn == decodePkg::CMP))
				b.rdTag = {4'b1110, rd[2:0]};
			else if (op == decodePkg::FLT2)
				b.rdTag = {2'b01, rd};
			else if (op == decodePkg::JSR)
				b.rdTag = {5'b11000, rd[1:0]};
			else if (op[7:6] == 2'b10 || b.isLoad || op == decodePkg::RTS)
				b.rdTag = {2'b00, rd};
			if (b.isPush || b.isPop || (mem && (w[29:28] == 2'd1 || w[29:28] == 2'd2)))
				b.rd2Tag = {2'b00, w[17:13]};
			b.regWrite = (b.rdTag != 7'd0) || (b.rd2Tag != 7'd0);
			b.btUpdate = op == decodePkg::JRL || op == decodePkg::RTS ||
				(op == decodePkg::MISC && (fn == decodePkg::BRK || fn == decodePkg::RTI));
			b.serialize = op == decodePkg::MISC && (fn == decodePkg::BRK ||
				fn == decodePkg::RTI || fn == decodePkg::SYNC);
			return b;
		end
	endfunction

	// ======================================================================
	// Compare tasks
	// ======================================================================
	task automatic checkUnit(input string name, input decodePkg::unitE e, a);
		if (a !== e)
		begin
			$display("ERR %s exp=%h act=%h instr=%h", name, e, a, curWord);
			errCount++;
		end
		else
			passCount++;
	endtask

	task automatic checkSize(input string name, input decodePkg::memSizeE e, a);
		if (a !== e)
		begin
			$display("ERR %s exp=%h act=%h instr=%h", name, e, a, curWord);
			errCount++;
		end
		else
			passCount++;
	endtask

	task automatic checkTag(input string name, input decodePkg::regTagT e, a);
		if (a !== e)
		begin
			$display("ERR %s exp=%h act=%h instr=%h", name, e, a, curWord);
			errCount++;
		end
		else
			passCount++;
	endtask

	task automatic checkConst(input string name, input logic [63:0] e, a);
		if (a !== e)
		begin
			$display("ERR %s exp=%h act=%h instr=%h", name, e, a, curWord);
			errCount++;
		end
		else
			passCount++;
	endtask

	task automatic checkFlag(input string name, input logic e, a);
		if (a !== e)
		begin
			$display("ERR %s exp=%h act=%h instr=%h", name, e, a, curWord);
			errCount++;
		end
		else
			passCount++;
	endtask

	task automatic compareBundle(input bundleT e);
		curWord = e.word;
		checkUnit("unitClass", e.unitClass, unitClass);
		checkSize("memSize", e.memSize, memSize);
		checkFlag("isLoad", e.isLoad, isLoad);
		checkFlag("isStore", e.isStore, isStore);
		checkFlag("isPush", e.isPush, isPush);
		checkFlag("isPop", e.isPop, isPop);
		checkFlag("isBranch", e.isBranch, isBranch);
		checkFlag("isJmp", e.isJmp, isJmp);
		checkFlag("canExcept", e.canExcept, canExcept);
		checkFlag("hasConst", e.hasConst, hasConst);
		checkConst("constVal", e.constVal, constVal);
		checkTag("rdTag", e.rdTag, rdTag);
		checkTag("rd2Tag", e.rd2Tag, rd2Tag);
		checkFlag("regWrite", e.regWrite, regWrite);
		checkFlag("btUpdate", e.btUpdate, btUpdate);
		checkFlag("serialize", e.serialize, serialize);
	endtask

	// Scoreboard with a count model of the queue
	always @(posedge clk)
	begin
		if (rst)
			modelCount = 0;
		else
		begin
			curWord = instr;
			checkFlag("inReady", modelCount != 2, inReady);
			checkFlag("outValid", modelCount != 0, outValid);
			if (inValid && inReady)
			begin
				expQ.push_back(decodeRef(instr, debugOn));
				sentCount++;
				modelCount++;
			end
			if (outValid && outReady)
			begin
				if (expQ.size() == 0)
				begin
					$display("Decoder delivered a word while none was outstanding");
					errCount++;
				end
				else
				begin
					compareBundle(expQ.pop_front());
					recvCount++;
				end
				modelCount--;
			end
		end
	end

	always @(posedge clk)
		cycleCount <= cycleCount + 1;

	initial
	begin
		wait (cycleCount >= cycleLimit);
		$display("Timeout after %0d cycles, the decode stage stopped making progress",
			cycleCount);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	// ======================================================================
	// Stimulus
	// ======================================================================
	task automatic nextCycle(output logic taken);
		logic [31:0] rnd;
		begin
			@(posedge clk);
			taken = inValid && inReady;
			@(negedge clk);
			rnd = $random(seed);
			outReady = stallOn ? rnd[0] : 1'b1;
		end
	endtask

	task automatic sendWord(input logic [39:0] w);
		logic taken;
		logic [31:0] rnd;
		begin
			// Random idle cycles while stalling
			rnd = $random(seed);
			while (stallOn && rnd[1])
			begin
				nextCycle(taken);
				rnd = $random(seed);
			end
			inValid = 1'b1;
			instr = w;
			taken = 1'b0;
			while (!taken)
				nextCycle(taken);
			inValid = 1'b0;
		end
	endtask

	task automatic drainQueue();
		stallOn = 1'b0;
		outReady = 1'b1;
		while (expQ.size() != 0)
			@(negedge clk);
	endtask

	function automatic logic [39:0] buildWord(input logic [7:0] op, input logic [1:0] am,
		input logic [5:0] fn, input logic [4:0] rd);
		return {4'hA, fn, am, 5'd22, 5'd17, 5'd3, rd, op};
	endfunction

	task automatic randomWord(output logic [39:0] w);
		logic [31:0] lo, hi, pick;
		begin
			lo = $random(seed);
			hi = $random(seed);
			pick = $random(seed);
			w = {hi[7:0], lo};
			w[7:0] = opList[pick[7:0] % 8'd26];
			w[35:30] = funcList[pick[15:8] % 8'd10];
		end
	endtask

	task automatic reportTest(input string name, input int sentBefore, errBefore);
		$display("Test %s finished: %0d words, %0d errors", name, sentCount - sentBefore,
			errCount - errBefore);
	endtask

	task automatic runRandom(input string name, input int count, input logic stall);
		int sentBefore, errBefore;
		logic [39:0] w;
		begin
			sentBefore = sentCount;
			errBefore = errCount;
			stallOn = stall;
			for (int i = 0; i < count; i++)
			begin
				randomWord(w);
				sendWord(w);
			end
			drainQueue();
			reportTest(name, sentBefore, errBefore);
		end
	endtask

	initial
	begin
		int errBefore;
		seed = 32'hcee259c0;
		inValid = 1'b0;
		instr = '0;
		debugOn = 1'b0;
		outReady = 1'b0;
		stallOn = 1'b0;
		curWord = '0;

		// Reset state, held through reset and a few cycles after it
		errBefore = errCount;
		@(posedge clk);
		while (rst)
		begin
			@(negedge clk);
			checkFlag("outValid", 1'b0, outValid);
			checkFlag("inReady", 1'b1, inReady);
		end
		outReady = 1'b1;
		repeat (3)
		begin
			@(negedge clk);
			checkFlag("outValid", 1'b0, outValid);
			checkFlag("inReady", 1'b1, inReady);
		end
		reportTest("reset", sentCount, errBefore);

		// Every opcode, each addressing mode and function variant
		errBefore = errCount;
		for (int i = 0; i < 26; i++)
		begin
			if (!opList[i][7])
				for (int am = 0; am < 4; am++)
					sendWord(buildWord(opList[i], 2'(am), 6'h00, 5'd9));
			else if (opList[i] == decodePkg::R2 || opList[i] == decodePkg::MISC ||
				opList[i] == decodePkg::FLT2)
				for (int f = 0; f < 10; f++)
					sendWord(buildWord(opList[i], 2'd0, funcList[f], 5'd9));
			else
				sendWord(buildWord(opList[i], 2'd0, 6'h00, 5'd9));
		end
		sendWord(buildWord(decodePkg::JSR, 2'd0, 6'h00, 5'd0));
		drainQueue();
		reportTest("directed", 0, errBefore);

		runRandom("random", 600, 1'b0);
		runRandom("backPressure", 150, 1'b1);
		debugOn = 1'b1;
		runRandom("debug", 100, 1'b0);
		debugOn = 1'b0;

		if (recvCount != sentCount)
		begin
			$display("Decoder delivered %0d words but %0d were accepted", recvCount, sentCount);
			errCount++;
		end
		$display("Checks passed %0d, errors %0d", passCount, errCount);
		if (errCount == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

//--- verification/clkGen.sv
// Testbench clock and reset
// 40 ns clock, synchronous reset held high for the first 16 rising edges

`timescale 1ns/10ps

module clkGen (
	output logic clk,
	output logic rst
);

	// 40 ns period
	initial
	begin
		clk = 1'b0;
		forever
			#20 clk = ~clk;
	end

	// Released on a falling edge like the other DUT inputs
	initial
	begin
		rst = 1'b1;
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
	end

endmodule

//--- design/decodeUnit.sv
// Instruction decode stage
// Fetch words enter a two-entry queue; the queue head is decoded
// combinationally into the control bundle for issue

`timescale 1ns/10ps

module decodeUnit (
	input  logic                             clk,
	input  logic                             rst,
	input  logic                             inValid,
	input  logic [decodePkg::instrWidth-1:0] instr,
	input  logic                             debugOn,
	input  logic                             outReady,
	output logic                             inReady,
	output logic                             outValid,
	output decodePkg::unitE                  unitClass,
	output decodePkg::memSizeE               memSize,
	output logic                             isLoad,
	output logic                             isStore,
	output logic                             isPush,
	output logic                             isPop,
	output logic                             isBranch,
	output logic                             isJmp,
	output logic                             canExcept,
	output logic                             hasConst,
	output logic [decodePkg::constWidth-1:0] constVal,
	output decodePkg::regTagT                rdTag,
	output decodePkg::regTagT                rd2Tag,
	output logic                             regWrite,
	output logic                             btUpdate,
	output logic                             serialize
);

	logic [decodePkg::instrWidth-1:0] headInstr;

	decodeQueue queue (.clk(clk), .rst(rst), .inValid(inValid), .instr(instr),
		.outReady(outReady), .inReady(inReady), .outValid(outValid), .head(headInstr));

	instrDecoder decoder (.instr(headInstr), .debugOn(debugOn),
		.unitClass(unitClass), .memSize(memSize), .isLoad(isLoad), .isStore(isStore),
		.isPush(isPush), .isPop(isPop), .isBranch(isBranch), .isJmp(isJmp),
		.canExcept(canExcept), .hasConst(hasConst), .constVal(constVal),
		.rdTag(rdTag), .rd2Tag(rd2Tag), .regWrite(regWrite),
		.btUpdate(btUpdate), .serialize(serialize));

endmodule

//--- design/decodeQueue.sv
// Decode queue
// Two-entry elastic buffer between fetch and the decoder. Slot 0 is the
// head, new words fill the next free slot and move up when the head
// leaves. inReady depends on the count only.

`timescale 1ns/10ps

module decodeQueue (
	input  logic                             clk,
	input  logic                             rst,
	input  logic                             inValid,
	input  logic [decodePkg::instrWidth-1:0] instr,
	input  logic                             outReady,
	output logic                             inReady,
	output logic                             outValid,
	output logic [decodePkg::instrWidth-1:0] head
);

	logic [1:0]                       count;
	logic [decodePkg::instrWidth-1:0] slot0;
	logic [decodePkg::instrWidth-1:0] slot1;
	logic                             push;
	logic                             pop;

	assign inReady  = (count != 2'd2);
	assign outValid = (count != 2'd0);
	assign head     = slot0;
	assign push     = inValid && inReady;
	assign pop      = outValid && outReady;

	always_ff @(posedge clk)
	begin
		if (rst)
			count <= 2'd0;
		else
			count <= count + {1'b0, push} - {1'b0, pop};
	end

	// Payload slots
	always_ff @(posedge clk)
	begin
		if (pop)
		begin
			// With two entries no push is possible, so slot 1 moves up
			slot0 <= (count == 2'd2) ? slot1 : instr;
		end
		else if (push)
		begin
			if (count == 2'd0)
				slot0 <= instr;
			else
				slot1 <= instr;
		end
	end

endmodule

//--- design/instrDecoder.sv
// Instruction decoder
// Purely combinational. Turns one instruction word into the control
// bundle for issue. Immediate and destination selection live in the
// two submodules.

`timescale 1ns/10ps

module instrDecoder (
	input  logic [decodePkg::instrWidth-1:0] instr,
	input  logic                             debugOn,
	output decodePkg::unitE                  unitClass,
	output decodePkg::memSizeE               memSize,
	output logic                             isLoad,
	output logic                             isStore,
	output logic                             isPush,
	output logic                             isPop,
	output logic                             isBranch,
	output logic                             isJmp,
	output logic                             canExcept,
	output logic                             hasConst,
	output logic [decodePkg::constWidth-1:0] constVal,
	output decodePkg::regTagT                rdTag,
	output decodePkg::regTagT                rd2Tag,
	output logic                             regWrite,
	output logic                             btUpdate,
	output logic                             serialize
);

	logic [7:0]        opBits;
	decodePkg::opcodeE opc;
	decodePkg::funcE   func;
	logic              isMem;
	logic              isMisc;
	logic              opExcept;

	assign opBits = instr[decodePkg::opcodeLo +: 8];
	assign opc    = decodePkg::opcodeE'(opBits);
	assign func   = decodePkg::funcE'(instr[decodePkg::funcLo +: 6]);
	assign isMem  = !opBits[7];
	assign isMisc = (opc == decodePkg::MISC);

	immGen imm (.instr(instr), .constVal(constVal), .hasConst(hasConst));

	regTargetSel targets (.instr(instr), .rdTag(rdTag), .rd2Tag(rd2Tag),
		.regWrite(regWrite));

	// ======================================================================
	// Class and access size
	// ======================================================================
	always_comb
	begin
		if (isMem)
			unitClass = decodePkg::unitMem;
		else if (opBits[7:6] == 2'b10)
			unitClass = decodePkg::unitAlu;
		else if (opBits[7:4] == 4'hE)
			unitClass = decodePkg::unitFpu;
		else if (opBits[7:5] == 3'b110)
			unitClass = decodePkg::unitFlow;
		else
			unitClass = decodePkg::unitNone;
	end

	always_comb
	begin
		case (opc)
			decodePkg::LDB, decodePkg::STB: memSize = decodePkg::byt;
			decodePkg::LDW, decodePkg::STW: memSize = decodePkg::wyde;
			decodePkg::LDT, decodePkg::STT: memSize = decodePkg::tetra;
			decodePkg::LDO, decodePkg::STO: memSize = decodePkg::octa;
			default: memSize = decodePkg::hexi;
		endcase
	end

	assign isLoad   = isMem && !opBits[5] && opc != decodePkg::LEA;
	assign isStore  = isMem && opBits[5];
	assign isPush   = (opc == decodePkg::PUSH);
	assign isPop    = (opc == decodePkg::POP);
	assign isBranch = (opc == decodePkg::BEQ) || (opc == decodePkg::BNE) ||
		(opc == decodePkg::BLT);
	assign isJmp    = (opc == decodePkg::JSR) && instr[decodePkg::rdLo +: 5] == 5'd0;

	// ======================================================================
	// Exceptions and flow side effects
	// ======================================================================
	always_comb
	begin
		case (opc)
			decodePkg::MULI, decodePkg::DIVI: opExcept = 1'b1;
			decodePkg::R2:   opExcept = (func == decodePkg::MUL) || (func == decodePkg::DIV);
			decodePkg::FLT2: opExcept = (func == decodePkg::FADD) ||
				(func == decodePkg::FMUL) || (func == decodePkg::FDIV);
			decodePkg::MISC: opExcept = (func == decodePkg::BRK);
			// Any memory access may fault
			default: opExcept = isMem;
		endcase
	end

	// Debug mode may break on anything
	assign canExcept = debugOn || opExcept;

	// Targets not known at fetch time update the BTB
	assign btUpdate  = (opc == decodePkg::JRL) || (opc == decodePkg::RTS) ||
		(isMisc && (func == decodePkg::BRK || func == decodePkg::RTI));
	assign serialize = isMisc && (func == decodePkg::SYNC || func == decodePkg::BRK ||
		func == decodePkg::RTI);

endmodule

//--- design/regTargetSel.sv
// Destination register selection
// Builds the primary and secondary destination tags from the opcode,
// function and register fields, and flags a register-file write

`timescale 1ns/10ps

module regTargetSel (
	input  logic [decodePkg::instrWidth-1:0] instr,
	output decodePkg::regTagT                rdTag,
	output decodePkg::regTagT                rd2Tag,
	output logic                             regWrite
);

	logic [7:0]        opBits;
	decodePkg::opcodeE opc;
	decodePkg::funcE   func;
	logic [4:0]        rd;
	logic [4:0]        rs1;
	logic [1:0]        am;

	assign opBits = instr[decodePkg::opcodeLo +: 8];
	assign opc    = decodePkg::opcodeE'(opBits);
	assign func   = decodePkg::funcE'(instr[decodePkg::funcLo +: 6]);
	assign rd     = instr[decodePkg::rdLo +: 5];
	assign rs1    = instr[decodePkg::rs1Lo +: 5];
	assign am     = instr[decodePkg::amLo +: 2];

	// Primary destination
	always_comb
	begin
		rdTag = '0;
		if (opc == decodePkg::CMPI)
			rdTag = {decodePkg::condPfx, rd[2:0]};
		else if (opc == decodePkg::R2)
			rdTag = (func == decodePkg::CMP) ? {decodePkg::condPfx, rd[2:0]} :
				{decodePkg::intPfx, rd};
		else if (opBits[7:6] == 2'b10)
			rdTag = {decodePkg::intPfx, rd};
		else if (opc == decodePkg::FLT2)
			rdTag = (func == decodePkg::FCMP) ? {decodePkg::condPfx, rd[2:0]} :
				{decodePkg::fltPfx, rd};
		else if (opc == decodePkg::JSR)
			rdTag = {decodePkg::linkPfx, rd[1:0]};
		else if (opc == decodePkg::RTS)
			rdTag = {decodePkg::intPfx, rd};
		// Loads, POP included
		else if (!opBits[7] && !opBits[5] && opc != decodePkg::LEA)
			rdTag = {decodePkg::intPfx, rd};
	end

	// Base register update for stack ops and auto-modify addressing
	always_comb
	begin
		rd2Tag = '0;
		if (opc == decodePkg::PUSH || opc == decodePkg::POP)
			rd2Tag = {decodePkg::intPfx, rs1};
		else if (!opBits[7] && (am == 2'd1 || am == 2'd2))
			rd2Tag = {decodePkg::intPfx, rs1};
	end

	assign regWrite = (rdTag != '0) || (rd2Tag != '0);

endmodule

//--- design/immGen.sv
// Immediate generator
// Picks the constant field for the instruction form and sign-extends it
// to the full constant width. Zero when the form carries no constant.

`timescale 1ns/10ps

module immGen (
	input  logic [decodePkg::instrWidth-1:0] instr,
	output logic [decodePkg::constWidth-1:0] constVal,
	output logic                             hasConst
);

	logic [7:0]         opBits;
	decodePkg::opcodeE  opc;
	logic               sgn;
	logic [14:0]        memImm;
	logic [21:0]        aluImm;
	logic [26:0]        jrlImm;

	assign opBits = instr[decodePkg::opcodeLo +: 8];
	assign opc    = decodePkg::opcodeE'(opBits);
	assign sgn    = instr[decodePkg::instrWidth-1];

	// Memory form skips the addressing mode bits
	assign memImm = {instr[decodePkg::instrWidth-1:decodePkg::funcLo],
		instr[decodePkg::rs3Lo +: 5]};
	assign aluImm = instr[decodePkg::instrWidth-1:decodePkg::rs2Lo];
	assign jrlImm = instr[decodePkg::instrWidth-1:decodePkg::rs1Lo];

	always_comb
	begin
		hasConst = 1'b0;
		constVal = '0;
		case (opc)
			decodePkg::ADDI, decodePkg::ANDI, decodePkg::ORI,
			decodePkg::CMPI, decodePkg::MULI, decodePkg::DIVI:
			begin
				hasConst = 1'b1;
				constVal = {{(decodePkg::constWidth - $bits(aluImm)){sgn}}, aluImm};
			end
			decodePkg::JRL:
			begin
				hasConst = 1'b1;
				constVal = {{(decodePkg::constWidth - $bits(jrlImm)){sgn}}, jrlImm};
			end
			default:
				// Displacement only with addressing mode 0, stack ops have none
				if (!opBits[7] && opc != decodePkg::PUSH && opc != decodePkg::POP &&
					instr[decodePkg::amLo +: 2] == 2'd0)
				begin
					hasConst = 1'b1;
					constVal = {{(decodePkg::constWidth - $bits(memImm)){sgn}}, memImm};
				end
		endcase
	end

endmodule

//--- design/decodePkg.sv
// Decode stage shared definitions
// Opcode and function encodings, functional-unit classes, access sizes,
// the destination tag format and the instruction field positions

package decodePkg;

	// ======================================================================
	// Instruction layout
	// ======================================================================
	localparam int instrWidth = 40;
	localparam int constWidth = 64;

	// Low bit of each field
	localparam int opcodeLo = 0;
	localparam int rdLo     = 8;
	localparam int rs1Lo    = 13;
	localparam int rs2Lo    = 18;
	localparam int rs3Lo    = 23;
	localparam int amLo     = 28;
	localparam int funcLo   = 30;

	// ======================================================================
	// Encodings
	// ======================================================================
	typedef enum logic [7:0] {
		// Memory class, opcode bit 7 clear
		LDB  = 8'h00, LDW  = 8'h01, LDT  = 8'h02, LDO  = 8'h03,
		POP  = 8'h0C, LEA  = 8'h0E,
		STB  = 8'h20, STW  = 8'h21, STT  = 8'h22, STO  = 8'h23,
		PUSH = 8'h2C,
		// ALU class
		ADDI = 8'h80, ANDI = 8'h81, ORI  = 8'h82, CMPI = 8'h83,
		MULI = 8'h84, DIVI = 8'h85, R2   = 8'hA0,
		// Flow control
		JSR  = 8'hC0, RTS  = 8'hC1, JRL  = 8'hC2,
		BEQ  = 8'hC8, BNE  = 8'hC9, BLT  = 8'hCA, MISC = 8'hD0,
		// Float
		FLT2 = 8'hE1
	} opcodeE;

	typedef enum logic [5:0] {
		ADD  = 6'h00, RTI  = 6'h01, SYNC = 6'h02, WAIT = 6'h03,
		FADD = 6'h04, CMP  = 6'h06, FMUL = 6'h08, FDIV = 6'h09,
		MUL  = 6'h10, DIV  = 6'h11
	} funcE;

	// MISC and FLT2 reuse these R2 encodings
	localparam funcE BRK  = ADD;
	localparam funcE FCMP = CMP;

	typedef enum logic [2:0] {
		unitNone, unitMem, unitAlu, unitFpu, unitFlow
	} unitE;

	typedef enum logic [2:0] {
		byt, wyde, tetra, octa, hexi
	} memSizeE;

	// ======================================================================
	// Destination tags
	// ======================================================================
	// Upper bits select the register file, zero means no destination
	typedef logic [6:0] regTagT;

	localparam logic [1:0] intPfx  = 2'b00;
	localparam logic [1:0] fltPfx  = 2'b01;
	localparam logic [4:0] linkPfx = 5'b11000;
	localparam logic [3:0] condPfx = 4'b1110;

endpackage
